/* rtl/prbs_link_pkg.sv */
package prbs_link_pkg;

    // lane count and generator geometry
    localparam int NUM_LANES        = 2;
    localparam int PRBS_WIDTH       = 8;                  // bits out per clock
    localparam int PRBS_ORDER       = 7;                  // x^7 + x^6 + 1
    localparam logic [PRBS_ORDER-1:0] PRBS_SEED = '1;     // all ones after reset

    // line coding, 8 symbols of 10 bits per word
    localparam int SYMBOL_WIDTH     = 10;
    localparam int SYMBOLS_PER_WORD = 8;
    localparam int WORD_WIDTH       = SYMBOL_WIDTH * SYMBOLS_PER_WORD;

    // K28.5 as pad, control flag, data byte
    localparam logic [SYMBOL_WIDTH-1:0] COMMA_K28_5 = {1'b0, 1'b1, 8'hBC};

    // checker lock threshold, counter must hold the value itself
    localparam int LOCK_COUNT       = 16;
    localparam int LOCK_CNT_WIDTH   = 5;

    // one 10-bit line symbol, seen as a raw code or split into fields
    typedef union packed {
        logic [SYMBOL_WIDTH-1:0] raw;                     // for comma compare
        struct packed {
            logic                  pad;                   // always 0 here
            logic                  ctrl;                  // k flag
            logic [PRBS_WIDTH-1:0] data;                  // payload byte
        } fld;
    } lane_symbol_u;

    // eight serial PRBS7 steps in one go
    // returns {next state, generated byte}, first bit lands in the msb
    function automatic logic [PRBS_ORDER+PRBS_WIDTH-1:0] prbs7_step8(
        input logic [PRBS_ORDER-1:0] state_in
    );
        logic [PRBS_ORDER-1:0] s;
        logic [PRBS_WIDTH-1:0] b;
        logic                  fb;
        s  = state_in;
        b  = '0;
        fb = 1'b0;
        for (int i = PRBS_WIDTH - 1; i >= 0; i--)
        begin
            fb   = s[PRBS_ORDER-1] ^ s[PRBS_ORDER-2];     // taps 7 and 6
            b[i] = fb;                                    // msb first
            s    = {s[PRBS_ORDER-2:0], fb};               // s[0] is newest bit
        end
        return {s, b};
    endfunction

endpackage

/* rtl/prbs7_gen.sv */
`timescale 1ns/10ps

module prbs7_gen (
    input  logic                                  rst_n_i,
    input  logic                                  q1_ln0_tx_clk,
    input  logic                                  gen_en_i,      // low holds the sequence
    output logic [prbs_link_pkg::PRBS_WIDTH-1:0]  prbs_byte_o    // shared by all lanes
);

    import prbs_link_pkg::*;

    logic [PRBS_ORDER-1:0]            state_q;     // lfsr state, s[0] newest
    logic [PRBS_ORDER+PRBS_WIDTH-1:0] step_pair;   // {next state, next byte}

    // next byte and state, one full byte per clock
    assign step_pair = prbs7_step8(state_q);

    // reset already presents the first seeded byte
    // so the first enabled edge moves on to byte two
    always_ff @(posedge q1_ln0_tx_clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            {state_q, prbs_byte_o} <= prbs7_step8(PRBS_SEED);   // constant after folding
        end
        else if (gen_en_i)
        begin
            {state_q, prbs_byte_o} <= step_pair;                // advance 8 bits
        end
    end

    // all-zero state would lock up the lfsr for good
    a_state_nonzero : assert property (
        @(posedge q1_ln0_tx_clk) disable iff (!rst_n_i)
        state_q != '0
    );

endmodule

/* rtl/prbs7_check.sv */
`timescale 1ns/10ps

module prbs7_check (
    input  logic                                  rst_n_i,
    input  logic                                  q1_ln0_tx_clk,
    input  logic                                  link_i,        // low keeps checker cleared
    input  logic [prbs_link_pkg::PRBS_WIDTH-1:0]  rx_byte_i,     // selected rx byte
    output logic                                  lock_o
);

    import prbs_link_pkg::*;

    logic [PRBS_WIDTH-1:0]            prev_q;      // last received byte
    logic [PRBS_ORDER+PRBS_WIDTH-1:0] pred_pair;   // {state, byte} from prev
    logic [PRBS_WIDTH-1:0]            pred_byte;   // expected current byte
    logic                             mismatch;    // current byte is bad
    logic                             err_q;       // registered compare result
    logic [LOCK_CNT_WIDTH-1:0]        cnt_q;       // consecutive good bytes

    // self-synchronizing, the last 7 rx bits are the lfsr state
    assign pred_pair = prbs7_step8(prev_q[PRBS_ORDER-1:0]);
    assign pred_byte = pred_pair[PRBS_WIDTH-1:0];

    // 0x00 never occurs in prbs7 (max zero run is 6)
    // rejecting it keeps a dead line from faking lock on zeros
    assign mismatch = (rx_byte_i != pred_byte) || (rx_byte_i == '0);

    // history byte, payload only
    always_ff @(posedge q1_ln0_tx_clk)
    begin
        prev_q <= rx_byte_i;
    end

    // compare result, one cycle after the byte enters
    always_ff @(posedge q1_ln0_tx_clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            err_q <= 1'b1;                      // nothing good seen yet
        end
        else
        begin
            err_q <= mismatch;
        end
    end

    // good-byte counter, saturates at the lock threshold
    always_ff @(posedge q1_ln0_tx_clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            cnt_q <= '0;
        end
        else if (!link_i || err_q)
        begin
            cnt_q <= '0;                        // link down or bad byte restarts
        end
        else if (cnt_q != LOCK_CNT_WIDTH'(LOCK_COUNT))
        begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // lock holds while the counter sits at the threshold
    assign lock_o = (cnt_q == LOCK_CNT_WIDTH'(LOCK_COUNT));

    // a low link clears lock by the next edge, so lock cannot rise meanwhile
    a_no_lock_without_link : assert property (
        @(posedge q1_ln0_tx_clk) disable iff (!rst_n_i)
        !link_i |=> !lock_o
    );

    a_cnt_in_range : assert property (
        @(posedge q1_ln0_tx_clk) disable iff (!rst_n_i)
        cnt_q <= LOCK_CNT_WIDTH'(LOCK_COUNT)
    );

endmodule

/* rtl/prbs_lane.sv */
`timescale 1ns/10ps

module prbs_lane (
    input  logic                                  rst_n_i,
    input  logic                                  q1_ln0_tx_clk,
    input  logic [prbs_link_pkg::PRBS_WIDTH-1:0]  prbs_byte_i,   // from shared generator
    input  logic                                  link_i,        // word-align link level
    input  logic [prbs_link_pkg::WORD_WIDTH-1:0]  rx_word_i,     // looped back word
    output logic [prbs_link_pkg::WORD_WIDTH-1:0]  tx_word_o,     // comma + 7 data symbols
    output logic                                  lock_o
);

    import prbs_link_pkg::*;

    lane_symbol_u                  tx_sym;     // padded data symbol for tx
    lane_symbol_u                  rx_sym0;    // lowest rx symbol
    lane_symbol_u                  rx_sym1;    // next rx symbol
    logic [2*SYMBOL_WIDTH-1:0]     rx_low_q;   // only symbols 0 and 1 matter
    logic [PRBS_WIDTH-1:0]         rx_byte;    // byte fed to the checker

    // data symbol, plain byte with pad and k flag low
    always_comb
    begin
        tx_sym.fld.pad  = 1'b0;
        tx_sym.fld.ctrl = 1'b0;
        tx_sym.fld.data = prbs_byte_i;
    end

    // tx word, comma in the top slot then 7 copies of the byte
    always_ff @(posedge q1_ln0_tx_clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            tx_word_o <= '0;                                    // idle until first byte
        end
        else
        begin
            tx_word_o <= {COMMA_K28_5, {(SYMBOLS_PER_WORD-1){tx_sym.raw}}};
        end
    end

    // rx capture, the comma can land in slot 0 after a symbol slip
    // so the two lowest symbols are all that is needed
    always_ff @(posedge q1_ln0_tx_clk)
    begin
        rx_low_q <= rx_word_i[2*SYMBOL_WIDTH-1:0];
    end

    assign rx_sym0 = rx_low_q[SYMBOL_WIDTH-1:0];
    assign rx_sym1 = rx_low_q[2*SYMBOL_WIDTH-1:SYMBOL_WIDTH];

    // comma in slot 0 means data starts at slot 1
    always_comb
    begin
        if (rx_sym0.raw == COMMA_K28_5)
        begin
            rx_byte = rx_sym1.fld.data;
        end
        else
        begin
            rx_byte = rx_sym0.fld.data;                         // straight alignment
        end
    end

    prbs7_check u_check (
        .rst_n_i       (rst_n_i),
        .q1_ln0_tx_clk (q1_ln0_tx_clk),
        .link_i        (link_i),
        .rx_byte_i     (rx_byte),
        .lock_o        (lock_o)
    );

endmodule

/* rtl/link_status.sv */
`timescale 1ns/10ps

module link_status (
    input  logic                                  rst_n_i,
    input  logic                                  q1_ln0_tx_clk,
    input  logic [prbs_link_pkg::NUM_LANES-1:0]   lane_lock_i,   // raw checker locks
    output logic [prbs_link_pkg::NUM_LANES-1:0]   lock_o,        // registered per lane
    output logic                                  all_lock_o,    // every lane locked
    output logic [prbs_link_pkg::NUM_LANES-1:0]   lost_lock_o    // sticky until reset
);

    import prbs_link_pkg::*;

    logic [NUM_LANES-1:0] lock_q;     // also the previous lock value
    logic [NUM_LANES-1:0] lost_q;
    logic [NUM_LANES-1:0] lock_fall;  // lock went 1 -> 0
    logic                 all_lock_q;

    // falling edge against the registered copy
    assign lock_fall = lock_q & ~lane_lock_i;

    always_ff @(posedge q1_ln0_tx_clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            lock_q     <= '0;
            lost_q     <= '0;
            all_lock_q <= 1'b0;
        end
        else
        begin
            lock_q     <= lane_lock_i;
            lost_q     <= lost_q | lock_fall;      // set only, reset clears
            all_lock_q <= &lock_q;                 // and of registered locks
        end
    end

    assign lock_o      = lock_q;
    assign all_lock_o  = all_lock_q;
    assign lost_lock_o = lost_q;

    // a raised loss flag has to survive until the next reset
    a_lost_sticky : assert property (
        @(posedge q1_ln0_tx_clk) disable iff (!rst_n_i)
        (lost_q & $past(lost_q)) == $past(lost_q)
    );

endmodule

/* rtl/prbs_link_top.sv */
`timescale 1ns/10ps

module prbs_link_top (
    input  logic                                  rst_n_i,
    input  logic                                  q1_ln0_tx_clk,  // single clock for tx and rx
    input  logic                                  gen_en_i,       // generator run level
    input  logic [prbs_link_pkg::NUM_LANES-1:0]   rx_link_i,      // per-lane link level
    input  logic [prbs_link_pkg::NUM_LANES*prbs_link_pkg::WORD_WIDTH-1:0] rx_word_i,
    output logic [prbs_link_pkg::NUM_LANES*prbs_link_pkg::WORD_WIDTH-1:0] tx_word_o,
    output logic [prbs_link_pkg::NUM_LANES-1:0]   lock_o,
    output logic                                  all_lock_o,
    output logic [prbs_link_pkg::NUM_LANES-1:0]   lost_lock_o
);

    import prbs_link_pkg::*;

    logic [PRBS_WIDTH-1:0] prbs_byte;   // one byte per clock to every lane
    logic [NUM_LANES-1:0]  lane_lock;   // raw checker locks

    // one generator feeds all lanes
    prbs7_gen u_gen (
        .rst_n_i       (rst_n_i),
        .q1_ln0_tx_clk (q1_ln0_tx_clk),
        .gen_en_i      (gen_en_i),
        .prbs_byte_o   (prbs_byte)
    );

    // lane l owns word slice l of the flat buses
    for (genvar l = 0; l < NUM_LANES; l++)
    begin : g_lane
        prbs_lane u_lane (
            .rst_n_i       (rst_n_i),
            .q1_ln0_tx_clk (q1_ln0_tx_clk),
            .prbs_byte_i   (prbs_byte),
            .link_i        (rx_link_i[l]),
            .rx_word_i     (rx_word_i[l*WORD_WIDTH +: WORD_WIDTH]),
            .tx_word_o     (tx_word_o[l*WORD_WIDTH +: WORD_WIDTH]),
            .lock_o        (lane_lock[l])
        );
    end

    // lock collection and sticky loss flags
    link_status u_status (
        .rst_n_i       (rst_n_i),
        .q1_ln0_tx_clk (q1_ln0_tx_clk),
        .lane_lock_i   (lane_lock),
        .lock_o        (lock_o),
        .all_lock_o    (all_lock_o),
        .lost_lock_o   (lost_lock_o)
    );

endmodule

/* test/tb_prbs_link_checker.sv */
`timescale 1ns/10ps

module tb_prbs_link_checker (
    input  logic                                                          q1_ln0_tx_clk,
    input  logic                                                          rst_n_i,
    input  logic                                                          gen_en_i,
    input  logic [prbs_link_pkg::NUM_LANES-1:0]                           rx_link_i,
    input  logic [prbs_link_pkg::NUM_LANES*prbs_link_pkg::WORD_WIDTH-1:0] rx_word_i,
    input  logic [prbs_link_pkg::NUM_LANES*prbs_link_pkg::WORD_WIDTH-1:0] tx_word_i,
    input  logic [prbs_link_pkg::NUM_LANES-1:0]                           lock_i,
    input  logic [prbs_link_pkg::NUM_LANES-1:0]                           lost_lock_i,
    output int                                                            errors_o
);

    import prbs_link_pkg::*;

    localparam int BUS_WIDTH = NUM_LANES * WORD_WIDTH;

    string                 cur_test     = "startup";
    int                    test_errs    = 0;           // errors in the running test
    int                    total_errs   = 0;
    int                    tests_run    = 0;
    int                    tests_failed = 0;
    int                    checks_done  = 0;
    logic [PRBS_WIDTH-1:0] model_byte;                 // reference generator byte
    logic [BUS_WIDTH-1:0]  model_tx;                   // expected tx bus
    logic [PRBS_WIDTH-1:0] last_sel [NUM_LANES];       // previous selected rx byte
    int                    good_run [NUM_LANES];       // good rx bytes in a row
    logic [NUM_LANES-1:0]  lock_seen    = '0;          // lock one sample back
    logic [NUM_LANES-1:0]  lost_seen    = '0;

    assign errors_o = total_errs;

    // bit recurrence b(n) = b(n-7) ^ b(n-6), hist[0] is the newest bit
    function automatic logic [PRBS_WIDTH-1:0] prbs_next_byte(input logic [6:0] hist);
        logic [14:0] stream;                           // oldest bit on top
        stream = {hist, 8'h00};
        for (int k = 7; k >= 0; k--)
        begin
            stream[k] = stream[k+7] ^ stream[k+6];
        end
        return stream[7:0];                            // first new bit in the msb
    endfunction

    // comma on top, then seven plain data symbols
    function automatic logic [WORD_WIDTH-1:0] expect_tx_word(input logic [PRBS_WIDTH-1:0] b);
        lane_symbol_u          sym;
        logic [WORD_WIDTH-1:0] w;
        sym.fld.pad  = 1'b0;
        sym.fld.ctrl = 1'b0;
        sym.fld.data = b;
        for (int i = 0; i < SYMBOLS_PER_WORD - 1; i++)
        begin
            w[i*SYMBOL_WIDTH +: SYMBOL_WIDTH] = sym.raw;
        end
        w[WORD_WIDTH-1 -: SYMBOL_WIDTH] = COMMA_K28_5;
        return w;
    endfunction

    // comma in slot 0 pushes the data to slot 1
    function automatic logic [PRBS_WIDTH-1:0] select_rx_byte(input logic [WORD_WIDTH-1:0] w);
        lane_symbol_u s0;
        lane_symbol_u s1;
        s0 = w[SYMBOL_WIDTH-1:0];
        s1 = w[2*SYMBOL_WIDTH-1:SYMBOL_WIDTH];
        return (s0.raw == COMMA_K28_5) ? s1.fld.data : s0.fld.data;
    endfunction

    task automatic check_value(input string test, input logic [BUS_WIDTH-1:0] exp,
                               input logic [BUS_WIDTH-1:0] act);
        checks_done++;
        if (act !== exp)
        begin
            $display("** Error %s: expected %0h, actual %0h", test, exp, act);
            test_errs++;
            total_errs++;
        end
    endtask

    task automatic report_fault(input string what);
        $display("error in %s: %s", cur_test, what);   // plain-words failure
        test_errs++;
        total_errs++;
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errs == 0)
        begin
            $display("test %-16s passed", cur_test);
        end
        else
        begin
            $display("test %-16s failed with %0d errors", cur_test, test_errs);
            tests_failed++;
        end
    endtask

    task automatic final_report();
        $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, checks_done, total_errs);
    endtask

    // reference generator and tx framing, one word per clock
    always @(posedge q1_ln0_tx_clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            model_byte <= prbs_next_byte(PRBS_SEED);   // first byte of the seeded run
            model_tx   <= '0;
        end
        else
        begin
            model_tx <= {NUM_LANES{expect_tx_word(model_byte)}};
            if (gen_en_i)
            begin
                model_byte <= prbs_next_byte(model_byte[6:0]);   // last 7 bits are the state
            end
        end
    end

    // good-byte run per lane, seen from the rx words
    always @(posedge q1_ln0_tx_clk or negedge rst_n_i)
    begin : run_model
        logic [PRBS_WIDTH-1:0] sel;
        for (int l = 0; l < NUM_LANES; l++)
        begin
            sel = select_rx_byte(rx_word_i[l*WORD_WIDTH +: WORD_WIDTH]);
            if (!rst_n_i)
            begin
                good_run[l] <= 0;
                last_sel[l] <= '0;
            end
            else
            begin
                // prbs7 never emits an all-zero byte
                if (rx_link_i[l] && sel != '0 && sel == prbs_next_byte(last_sel[l][6:0]))
                begin
                    good_run[l] <= good_run[l] + 1;
                end
                else
                begin
                    good_run[l] <= 0;
                end
                last_sel[l] <= sel;
            end
        end
    end

    // compare away from the active edge
    always @(negedge q1_ln0_tx_clk)
    begin
        check_value({cur_test, " tx_word_o"}, model_tx, tx_word_i);
        for (int l = 0; l < NUM_LANES; l++)
        begin
            if (rst_n_i && lost_seen[l] && !lost_lock_i[l])
            begin
                report_fault($sformatf("lost_lock_o[%0d] cleared without a reset", l));
            end
            if (rst_n_i && lock_i[l] && !lock_seen[l] && good_run[l] < LOCK_COUNT)
            begin
                report_fault($sformatf("lane %0d locked after only %0d good bytes",
                                       l, good_run[l]));
            end
        end
        lock_seen = lock_i;
        lost_seen = rst_n_i ? lost_lock_i : '0;
    end

endmodule

/* test/tb_prbs_link.sv */
`timescale 1ns/10ps

module tb_prbs_link;

    import prbs_link_pkg::*;

    localparam int LOCK_LIMIT   = LOCK_COUNT + 6;   // reset to all-lock is 22 edges
    localparam int LINK_DROP    = 2;                // clear, then status register
    localparam int FLIP_DROP    = 5;                // loopback edge + capture, compare, count, status
    localparam int HOLD_DROP    = 6;                // repeat reaches rx one edge later
    localparam int FRAME_CYCLES = 8;
    // about 20 bounded waits at their limits, plus margin
    localparam int TIMEOUT_CYCLES = 20 * LOCK_LIMIT + 360;
    localparam int PROBE_LOCK   = 0;
    localparam int PROBE_ALL    = 1;
    localparam int PROBE_LOST   = 2;

    logic                            rst_n_i;
    logic                            q1_ln0_tx_clk = 1'b0;
    logic                            gen_en_i;
    logic [NUM_LANES-1:0]            rx_link_i;
    logic [NUM_LANES*WORD_WIDTH-1:0] rx_word_i;
    logic [NUM_LANES*WORD_WIDTH-1:0] tx_word_o;
    logic [NUM_LANES-1:0]            lock_o;
    logic                            all_lock_o;
    logic [NUM_LANES-1:0]            lost_lock_o;

    logic [NUM_LANES-1:0] rotate;          // slip lane word by one symbol
    logic [NUM_LANES-1:0] flip_req;        // one-shot bit error, per lane
    int                   flip_bit;
    logic [31:0]          rnd_state;
    logic                 watch_lane1;
    logic                 lane1_dropped;
    int                   cycles = 0;
    int                   errors;

    prbs_link_top uut (
        .rst_n_i       (rst_n_i),
        .q1_ln0_tx_clk (q1_ln0_tx_clk),
        .gen_en_i      (gen_en_i),
        .rx_link_i     (rx_link_i),
        .rx_word_i     (rx_word_i),
        .tx_word_o     (tx_word_o),
        .lock_o        (lock_o),
        .all_lock_o    (all_lock_o),
        .lost_lock_o   (lost_lock_o)
    );

    tb_prbs_link_checker u_chk (
        .q1_ln0_tx_clk (q1_ln0_tx_clk),
        .rst_n_i       (rst_n_i),
        .gen_en_i      (gen_en_i),
        .rx_link_i     (rx_link_i),
        .rx_word_i     (rx_word_i),
        .tx_word_i     (tx_word_o),
        .lock_i        (lock_o),
        .lost_lock_i   (lost_lock_o),
        .errors_o      (errors)
    );

    always #20 q1_ln0_tx_clk = ~q1_ln0_tx_clk;          // 40 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic sample_status(input int what, input int lane);
        case (what)
            PROBE_LOCK: return lock_o[lane];
            PROBE_ALL:  return all_lock_o;
            default:    return lost_lock_o[lane];
        endcase
    endfunction

    // serial loopback, the testbench stands in for the line
    always @(posedge q1_ln0_tx_clk)
    begin : loopback
        logic [WORD_WIDTH-1:0] w;
        #2;
        for (int l = 0; l < NUM_LANES; l++)
        begin
            w = tx_word_o[l*WORD_WIDTH +: WORD_WIDTH];
            if (rotate[l])
            begin
                w = {w[WORD_WIDTH-SYMBOL_WIDTH-1:0], w[WORD_WIDTH-1 -: SYMBOL_WIDTH]};
            end
            if (flip_req[l])
            begin
                w[flip_bit] = ~w[flip_bit];
            end
            rx_word_i[l*WORD_WIDTH +: WORD_WIDTH] = w;
        end
        flip_req = '0;                                  // single word only
    end

    always @(negedge q1_ln0_tx_clk)
    begin
        if (watch_lane1 && !lock_o[1])
        begin
            lane1_dropped = 1'b1;                       // lane 1 must ride through lane 0 errors
        end
    end

    always @(posedge q1_ln0_tx_clk)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("run timed out after %0d cycles, a lock or drop never settled", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic next_drive_slot();
        @(posedge q1_ln0_tx_clk);
        #2;
    endtask

    // wait for a status level, edges counted, then compare
    task automatic wait_level(input string label, input int what, input int lane,
                              input logic level, input int limit);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < limit)
        begin
            @(posedge q1_ln0_tx_clk);
            @(negedge q1_ln0_tx_clk);
            n++;
            seen = (sample_status(what, lane) == level);
        end
        u_chk.check_value(label, level, sample_status(what, lane));
    endtask

    initial
    begin
        rst_n_i       = 1'b0;
        gen_en_i      = 1'b0;
        rx_link_i     = '1;
        rx_word_i     = '0;
        rotate        = '0;
        flip_req      = '0;
        flip_bit      = 0;
        rnd_state     = 32'd73909;
        watch_lane1   = 1'b0;
        lane1_dropped = 1'b0;

        u_chk.begin_test("reset_state");
        repeat (3)
        begin
            @(negedge q1_ln0_tx_clk);
            u_chk.check_value("reset_state status", '0, {lock_o, all_lock_o, lost_lock_o});
            u_chk.check_value("reset_state tx_word_o", '0, tx_word_o);
        end
        u_chk.end_test();
        next_drive_slot();
        rst_n_i  = 1'b1;
        gen_en_i = 1'b1;

        u_chk.begin_test("tx_framing");                 // monitor compares every word
        repeat (FRAME_CYCLES) @(negedge q1_ln0_tx_clk);
        u_chk.end_test();

        u_chk.begin_test("straight_lock");
        wait_level("straight_lock lock_o[0]", PROBE_LOCK, 0, 1'b1, LOCK_LIMIT);
        wait_level("straight_lock lock_o[1]", PROBE_LOCK, 1, 1'b1, LOCK_LIMIT);
        wait_level("straight_lock all_lock_o", PROBE_ALL, 0, 1'b1, 3);
        u_chk.end_test();

        u_chk.begin_test("rotated_lane1");
        next_drive_slot();
        rx_link_i[1] = 1'b0;
        wait_level("rotated_lane1 lock_o[1] clear", PROBE_LOCK, 1, 1'b0, LINK_DROP);
        rotate[1] = 1'b1;                               // comma now in symbol 0
        next_drive_slot();
        rx_link_i[1] = 1'b1;
        wait_level("rotated_lane1 lock_o[1]", PROBE_LOCK, 1, 1'b1, LOCK_LIMIT);
        u_chk.end_test();

        u_chk.begin_test("bit_flip_lane0");
        rnd_state     = xorshift32(rnd_state);
        flip_bit      = int'(rnd_state % PRBS_WIDTH);   // data bits of symbol 0
        watch_lane1   = 1'b1;
        lane1_dropped = 1'b0;
        flip_req[0]   = 1'b1;
        wait_level("bit_flip_lane0 lock_o[0] drop", PROBE_LOCK, 0, 1'b0, FLIP_DROP);
        wait_level("bit_flip_lane0 lost_lock_o[0]", PROBE_LOST, 0, 1'b1, 1);
        wait_level("bit_flip_lane0 lock_o[0] relock", PROBE_LOCK, 0, 1'b1, LOCK_LIMIT);
        watch_lane1 = 1'b0;
        u_chk.check_value("bit_flip_lane0 lock_o[1] held", 1'b1, !lane1_dropped);
        u_chk.end_test();

        u_chk.begin_test("link_drop_lane0");
        next_drive_slot();
        rx_link_i[0] = 1'b0;
        wait_level("link_drop_lane0 lock_o[0] clear", PROBE_LOCK, 0, 1'b0, LINK_DROP);
        next_drive_slot();
        rx_link_i[0] = 1'b1;
        wait_level("link_drop_lane0 lock_o[0] relock", PROBE_LOCK, 0, 1'b1, LOCK_LIMIT);
        u_chk.end_test();

        u_chk.begin_test("gen_hold");
        next_drive_slot();
        gen_en_i = 1'b0;                                // repeated bytes break prediction
        wait_level("gen_hold lock_o[0] drop", PROBE_LOCK, 0, 1'b0, HOLD_DROP);
        wait_level("gen_hold lock_o[1] drop", PROBE_LOCK, 1, 1'b0, HOLD_DROP);
        next_drive_slot();
        gen_en_i = 1'b1;
        wait_level("gen_hold all_lock_o relock", PROBE_ALL, 0, 1'b1, LOCK_LIMIT + 2);
        u_chk.check_value("gen_hold lost_lock_o", {NUM_LANES{1'b1}}, lost_lock_o);
        u_chk.end_test();

        next_drive_slot();                              // let the last compares settle
        u_chk.final_report();
        if (errors == 0)
        begin
            $display("=== PASS ===");
        end
        else
        begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* verilog.f */
rtl/prbs_link_pkg.sv
rtl/prbs7_gen.sv
rtl/prbs7_check.sv
rtl/prbs_lane.sv
rtl/link_status.sv
rtl/prbs_link_top.sv
test/tb_prbs_link_checker.sv
test/tb_prbs_link.sv

/* Bender.yml */
package:
  name: prbs_link

sources:
  - rtl/prbs_link_pkg.sv
  - rtl/prbs7_gen.sv
  - rtl/prbs7_check.sv
  - rtl/prbs_lane.sv
  - rtl/link_status.sv
  - rtl/prbs_link_top.sv
  - target: test
    files:
      - test/tb_prbs_link_checker.sv
      - test/tb_prbs_link.sv
